//--- common/mipsPkg.sv
package mipsPkg;

    typedef logic [31:0] word;      // Data and PC values
    typedef logic [4:0]  regAddr;   // GPR number
    typedef logic [5:0]  opId;      // Internal instruction id
    typedef logic [1:0]  tnewT;
    typedef logic [2:0]  funcClass;

    // Instruction identifiers
    localparam opId OP_NOP    = 6'd0;
    localparam opId OP_ADDU   = 6'd1;
    localparam opId OP_SUBU   = 6'd2;
    localparam opId OP_ORI    = 6'd3;
    localparam opId OP_LW     = 6'd4;
    localparam opId OP_SW     = 6'd5;
    localparam opId OP_LUI    = 6'd6;
    localparam opId OP_BEQ    = 6'd7;
    localparam opId OP_BNE    = 6'd8;
    localparam opId OP_BGEZAL = 6'd9;
    localparam opId OP_BLTZAL = 6'd10;
    localparam opId OP_J      = 6'd11;
    localparam opId OP_JAL    = 6'd12;
    localparam opId OP_JR     = 6'd13;
    localparam opId OP_JALR   = 6'd14;
    localparam opId OP_MOVZ   = 6'd15;
    localparam opId OP_MOVN   = 6'd16;
    localparam opId OP_MFHI   = 6'd17;
    localparam opId OP_MFLO   = 6'd18;

    // Function classes
    localparam funcClass FC_CALC_R    = 3'd0;
    localparam funcClass FC_CALC_I    = 3'd1;
    localparam funcClass FC_MEM_READ  = 3'd2;
    localparam funcClass FC_MEM_WRITE = 3'd3;
    localparam funcClass FC_BRANCH    = 3'd4;
    localparam funcClass FC_JUMP      = 3'd5;
    localparam funcClass FC_OTHER     = 3'd6;

    localparam regAddr LINK_REG = 5'd31;

    // Younger result from EX or MEM
    typedef struct packed {
        regAddr addr;
        word    data;
    } fwdSrc;

    typedef struct packed {
        opId         op;
        funcClass    fc;
        regAddr      rs;
        regAddr      rt;
        regAddr      rd;
        logic [15:0] imm16;
        logic [4:0]  shamt;
        logic [25:0] jmpAddr;
    } decodedInstr;

    // Everything the next-PC logic needs
    typedef struct packed {
        opId         instr;
        logic        cmp;
        logic [15:0] imm16;
        logic [25:0] jmpAddr;
        word         jmpReg;
    } npcInfo;

    typedef struct packed {
        opId         instr;
        word         pc;
        word         dataRs;
        word         dataRt;
        logic [15:0] imm16;
        logic [4:0]  shamt;
        regAddr      addrRs;
        regAddr      addrRt;
        regAddr      regWriteAddr;
        word         regWriteData;
        tnewT        tnew;
    } idExReg;

endpackage

//--- decode/branchCompare.sv
`timescale 1ns/1ps

module branchCompare (
    input  mipsPkg::opId op,
    input  mipsPkg::word dataRs,
    input  mipsPkg::word dataRt,
    output logic         cmp
);
    import mipsPkg::*;

    always_comb begin
        case (op)
            OP_BEQ:    cmp = (dataRs == dataRt);
            OP_BNE:    cmp = (dataRs != dataRt);
            OP_BGEZAL: cmp = ~dataRs[31];   // Signed rs >= 0
            OP_BLTZAL: cmp = dataRs[31];
            // Conditional moves test rt only
            OP_MOVZ:   cmp = (dataRt == '0);
            OP_MOVN:   cmp = (dataRt != '0);
            default:   cmp = 1'b0;
        endcase
    end

endmodule

//--- decode/idStage.sv
`timescale 1ns/1ps

module idStage (
    input  logic            clk,
    input  logic            rst,
    input  mipsPkg::word    code,
    input  mipsPkg::word    pc,
    input  mipsPkg::fwdSrc  fwdEx,
    input  mipsPkg::fwdSrc  fwdMem,
    input  mipsPkg::tnewT   tnewIn,
    input  logic            stall,
    input  logic            clr,
    input  mipsPkg::word    rdata1,
    input  mipsPkg::word    rdata2,
    output mipsPkg::regAddr raddr1,
    output mipsPkg::regAddr raddr2,
    output mipsPkg::idExReg idEx,
    output mipsPkg::npcInfo npc,
    output mipsPkg::opId    hazInstr,
    output mipsPkg::regAddr hazRs,
    output mipsPkg::regAddr hazRt
);
    import mipsPkg::*;

    decodedInstr dec;
    word         dataRs;
    word         dataRt;
    logic        cmp;
    regAddr      wrAddr;
    word         wrData;
    tnewT        tnewAged;
    idExReg      idExNext;

    // EX beats MEM beats the register file
    function automatic word fwdSel(regAddr src, fwdSrc ex, fwdSrc mem, word rf);
        if (ex.addr != '0 && ex.addr == src) begin
            return ex.data;
        end
        if (mem.addr != '0 && mem.addr == src) begin
            return mem.data;
        end
        return rf;
    endfunction

    instrDecoder u_instrDecoder (
        .code (code),
        .dec  (dec)
    );

    assign raddr1 = dec.rs;
    assign raddr2 = dec.rt;

    assign dataRs = fwdSel(dec.rs, fwdEx, fwdMem, rdata1);
    assign dataRt = fwdSel(dec.rt, fwdEx, fwdMem, rdata2);

    branchCompare u_branchCompare (
        .op     (dec.op),
        .dataRs (dataRs),
        .dataRt (dataRt),
        .cmp    (cmp)
    );

    // Destination register
    always_comb begin
        if (dec.op == OP_BGEZAL || dec.op == OP_BLTZAL) begin
            wrAddr = cmp ? LINK_REG : '0;   // Link only when taken
        end else if (dec.op == OP_MOVZ || dec.op == OP_MOVN) begin
            wrAddr = cmp ? dec.rd : '0;
        end else if (dec.op == OP_JAL) begin
            wrAddr = LINK_REG;
        end else if (dec.fc == FC_CALC_R || dec.op == OP_JALR ||
                     dec.op == OP_MFHI || dec.op == OP_MFLO) begin
            wrAddr = dec.rd;
        end else if (dec.fc == FC_CALC_I || dec.fc == FC_MEM_READ) begin
            wrAddr = dec.rt;
        end else begin
            wrAddr = '0;
        end
    end

    // Write-back value where ID already knows it
    always_comb begin
        if (dec.op == OP_MOVZ || dec.op == OP_MOVN) begin
            wrData = cmp ? dataRs : '0;
        end else if (dec.op == OP_JAL || dec.op == OP_JALR ||
                     dec.op == OP_BGEZAL || dec.op == OP_BLTZAL) begin
            wrData = pc + 32'd8;   // Return address past the delay slot
        end else if (dec.op == OP_LUI) begin
            wrData = {dec.imm16, 16'h0000};
        end else begin
            wrData = '0;
        end
    end

    assign tnewAged = (tnewIn != '0) ? tnewIn - 2'd1 : '0;

    assign idExNext.instr        = dec.op;
    assign idExNext.pc           = pc;
    assign idExNext.dataRs       = dataRs;
    assign idExNext.dataRt       = dataRt;
    assign idExNext.imm16        = dec.imm16;
    assign idExNext.shamt        = dec.shamt;
    assign idExNext.addrRs       = dec.rs;
    assign idExNext.addrRt       = dec.rt;
    assign idExNext.regWriteAddr = wrAddr;
    assign idExNext.regWriteData = wrData;
    assign idExNext.tnew         = tnewAged;

    // Bubble on clear and hold on stall
    always_ff @(posedge clk) begin
        if (rst || clr) begin
            idEx <= '0;
        end else if (!stall) begin
            idEx <= idExNext;
        end
    end

    assign npc.instr   = dec.op;
    assign npc.cmp     = cmp;
    assign npc.imm16   = dec.imm16;
    assign npc.jmpAddr = dec.jmpAddr;
    assign npc.jmpReg  = dataRs;   // JR and JALR target

    assign hazInstr = dec.op;
    assign hazRs    = dec.rs;
    assign hazRt    = dec.rt;

    resetBubble: assert property (@(posedge clk) rst |=> idEx.regWriteAddr == '0);

    noWriteFromNop: assert property (@(posedge clk) disable iff (rst)
        idEx.regWriteAddr != '0 |-> idEx.instr != OP_NOP);

endmodule

//--- decode/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  mipsPkg::word         code,
    output mipsPkg::decodedInstr dec
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] regimm;

    assign opcode = code[31:26];
    assign funct  = code[5:0];
    assign regimm = code[20:16];   // REGIMM selector sits in the rt slot

    // Operand fields are passed through raw
    assign dec.rs      = code[25:21];
    assign dec.rt      = code[20:16];
    assign dec.rd      = code[15:11];
    assign dec.shamt   = code[10:6];
    assign dec.imm16   = code[15:0];
    assign dec.jmpAddr = code[25:0];

    always_comb begin
        dec.op = OP_NOP;   // Unknown words fall through as NOP
        dec.fc = FC_OTHER;
        case (opcode)
            6'h00: begin   // SPECIAL
                case (funct)
                    6'h21: begin
                        dec.op = OP_ADDU;
                        dec.fc = FC_CALC_R;
                    end
                    6'h23: begin
                        dec.op = OP_SUBU;
                        dec.fc = FC_CALC_R;
                    end
                    6'h08: begin
                        dec.op = OP_JR;
                        dec.fc = FC_JUMP;
                    end
                    6'h09: begin
                        dec.op = OP_JALR;
                        dec.fc = FC_JUMP;
                    end
                    6'h0a: dec.op = OP_MOVZ;
                    6'h0b: dec.op = OP_MOVN;
                    6'h10: dec.op = OP_MFHI;
                    6'h12: dec.op = OP_MFLO;
                    default: ;
                endcase
            end
            6'h01: begin   // REGIMM
                if (regimm == 5'h11) begin
                    dec.op = OP_BGEZAL;
                    dec.fc = FC_BRANCH;
                end else if (regimm == 5'h10) begin
                    dec.op = OP_BLTZAL;
                    dec.fc = FC_BRANCH;
                end
            end
            6'h02: begin
                dec.op = OP_J;
                dec.fc = FC_JUMP;
            end
            6'h03: begin
                dec.op = OP_JAL;
                dec.fc = FC_JUMP;
            end
            6'h04: begin
                dec.op = OP_BEQ;
                dec.fc = FC_BRANCH;
            end
            6'h05: begin
                dec.op = OP_BNE;
                dec.fc = FC_BRANCH;
            end
            6'h0d: begin
                dec.op = OP_ORI;
                dec.fc = FC_CALC_I;
            end
            6'h0f: begin
                dec.op = OP_LUI;
                dec.fc = FC_CALC_I;   // Writes rt like other I-type ALU ops
            end
            6'h23: begin
                dec.op = OP_LW;
                dec.fc = FC_MEM_READ;
            end
            6'h2b: begin
                dec.op = OP_SW;
                dec.fc = FC_MEM_WRITE;
            end
            default: ;
        endcase
    end

endmodule

//--- logic/idTop.sv
`timescale 1ns/1ps

module idTop (
    input  logic            clk,
    input  logic            rst,
    input  mipsPkg::word    code,
    input  mipsPkg::word    pc,
    input  mipsPkg::fwdSrc  fwdEx,
    input  mipsPkg::fwdSrc  fwdMem,
    input  logic            wbEn,
    input  mipsPkg::regAddr wbAddr,
    input  mipsPkg::word    wbData,
    input  mipsPkg::tnewT   tnewIn,
    input  logic            stall,
    input  logic            clr,
    output mipsPkg::idExReg idEx,
    output mipsPkg::npcInfo npc,
    output mipsPkg::opId    hazInstr,
    output mipsPkg::regAddr hazRs,
    output mipsPkg::regAddr hazRt
);
    import mipsPkg::*;

    regAddr raddr1;
    regAddr raddr2;
    word    rdata1;
    word    rdata2;

    regFile u_regFile (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .wen    (wbEn),     // Write-back port
        .waddr  (wbAddr),
        .wdata  (wbData),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    idStage u_idStage (
        .clk      (clk),
        .rst      (rst),
        .code     (code),
        .pc       (pc),
        .fwdEx    (fwdEx),
        .fwdMem   (fwdMem),
        .tnewIn   (tnewIn),
        .stall    (stall),
        .clr      (clr),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .raddr1   (raddr1),
        .raddr2   (raddr2),
        .idEx     (idEx),
        .npc      (npc),
        .hazInstr (hazInstr),
        .hazRs    (hazRs),
        .hazRt    (hazRt)
    );

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic            clk,
    input  logic            rst,
    input  mipsPkg::regAddr raddr1,
    input  mipsPkg::regAddr raddr2,
    input  logic            wen,
    input  mipsPkg::regAddr waddr,
    input  mipsPkg::word    wdata,
    output mipsPkg::word    rdata1,
    output mipsPkg::word    rdata2
);
    import mipsPkg::*;

    word regs [1:31];   // $0 has no storage

    // Zero register, then same-cycle write, then array
    function automatic word readPort(regAddr addr);
        if (addr == '0) begin
            return '0;
        end
        if (wen && waddr == addr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb rdata1 = readPort(raddr1);
    always_comb rdata2 = readPort(raddr2);

    // A write to $0 leaves every stored register as it was
    zeroRegHolds: assert property (@(posedge clk) disable iff (rst)
        (wen && waddr == '0) ##1 (!wen && raddr1 == $past(raddr1))
        |-> rdata1 == $past(rdata1));

endmodule

//--- src.f
common/mipsPkg.sv
decode/instrDecoder.sv
decode/branchCompare.sv
decode/idStage.sv
logic/regFile.sv
logic/idTop.sv
verif/idTopTb.sv

//--- verif/idTests.txt
# name code pc exAddr exData memAddr memData wbEn wbAddr wbData tnewIn stall clr (all hex)
# then npc: instr cmp imm16 jmpAddr jmpReg, idEx: instr pc rs rt imm16 shamt aRs aRt wa wd tnew
lui 3c091234 400 0 0 0 0 1 4 10 0 0 0 6 0 1234 0091234 0 6 400 0 0 1234 8 0 9 9 12340000 0
adduWbFwd 00851821 404 0 0 0 0 1 5 3 0 0 0 1 0 1821 0851821 10 1 404 10 3 1821 0 4 5 3 0 0
oriTnew2 348200ff 408 0 0 0 0 1 6 fffffff0 2 0 0 3 0 ff 08200ff 10 3 408 10 0 ff 3 4 2 2 0 1
lwTnew3 8ca80020 40c 0 0 0 0 0 0 0 3 0 0 4 0 20 0a80020 3 4 40c 3 0 20 0 5 8 8 0 2
swTnew1 acc40004 410 0 0 0 0 0 0 0 1 0 0 5 0 4 0c40004 fffffff0 5 410 fffffff0 10 4 0 6 4 0 0 0
fwdExOverMem 00851823 414 4 aaaa 4 bbbb 0 0 0 0 0 0 2 0 1823 0851823 aaaa 2 414 aaaa 3 1823 0 4 5 3 0 0
fwdZeroAddr 00051823 418 0 1111 5 bbbb 0 0 0 0 0 0 2 0 1823 0051823 0 2 418 0 bbbb 1823 0 0 5 3 0 0
beqTaken 10a50010 41c 0 0 0 0 0 0 0 0 0 0 7 1 10 0a50010 3 7 41c 3 3 10 0 5 5 0 0 0
bneTaken 1485fffc 420 0 0 0 0 0 0 0 0 0 0 8 1 fffc 085fffc 10 8 420 10 3 fffc 1f 4 5 0 0 0
bgezalNot 04d10008 424 0 0 0 0 0 0 0 0 0 0 9 0 8 0d10008 fffffff0 9 424 fffffff0 0 8 0 6 11 0 42c 0
bltzalTaken 04d00008 428 0 0 0 0 0 0 0 0 0 0 a 1 8 0d00008 fffffff0 a 428 fffffff0 0 8 0 6 10 1f 430 0
movzNot 0085500a 42c 0 0 0 0 0 0 0 0 0 0 f 0 500a 085500a 10 f 42c 10 3 500a 0 4 5 0 0 0
movnTaken 0085500b 430 0 0 0 0 0 0 0 0 0 0 10 1 500b 085500b 10 10 430 10 3 500b 0 4 5 a 10 0
j 08100040 434 0 0 0 0 0 0 0 0 0 0 b 0 40 0100040 0 b 434 0 0 40 1 0 10 0 0 0
jal 0c000100 438 0 0 0 0 0 0 0 0 0 0 c 0 100 0000100 0 c 438 0 0 100 4 0 0 1f 440 0
jr 00800008 43c 0 0 0 0 0 0 0 0 0 0 d 0 8 0800008 10 d 43c 10 0 8 0 4 0 0 0 0
jalrFwd 00a05809 440 5 1000 0 0 0 0 0 0 0 0 e 0 5809 0a05809 1000 e 440 1000 0 5809 0 5 0 b 448 0
stallHold 00851821 500 0 0 0 0 0 0 0 2 1 0 1 0 1821 0851821 10 e 440 1000 0 5809 0 5 0 b 448 0
clrStall 00851821 504 0 0 0 0 0 0 0 0 1 1 1 0 1821 0851821 10 0 0 0 0 0 0 0 0 0 0 0
oriTnew3 348200ff 508 0 0 0 0 0 0 0 3 0 0 3 0 ff 08200ff 10 3 508 10 0 ff 3 4 2 2 0 2
clrOnly 348200ff 50c 0 0 0 0 0 0 0 3 0 1 3 0 ff 08200ff 10 0 0 0 0 0 0 0 0 0 0 0

//--- verif/idTopTb.sv
`timescale 1ns/1ps

module idTopTb;
    import mipsPkg::*;

    localparam int PERIOD    = 100;
    localparam int MAX_TESTS = 64;
    localparam int NUM_COLS  = 28;   // Hex columns after the test name

    logic   clk;
    logic   rst;
    word    code;
    word    pc;
    fwdSrc  fwdEx;
    fwdSrc  fwdMem;
    logic   wbEn;
    regAddr wbAddr;
    word    wbData;
    tnewT   tnewIn;
    logic   stall;
    logic   clr;
    idExReg idEx;
    npcInfo npc;
    opId    hazInstr;
    regAddr hazRs;
    regAddr hazRt;

    string       names [0:MAX_TESTS-1];
    logic [31:0] cols [0:MAX_TESTS-1][0:NUM_COLS-1];
    int          numTests    = 0;
    bit          loaded      = 1'b0;
    int          npcErrors   = 0;
    int          idExErrors  = 0;
    int          hazErrors   = 0;
    int          otherErrors = 0;

    idTop i_idTop (
        .clk      (clk),
        .rst      (rst),
        .code     (code),
        .pc       (pc),
        .fwdEx    (fwdEx),
        .fwdMem   (fwdMem),
        .wbEn     (wbEn),
        .wbAddr   (wbAddr),
        .wbData   (wbData),
        .tnewIn   (tnewIn),
        .stall    (stall),
        .clr      (clr),
        .idEx     (idEx),
        .npc      (npc),
        .hazInstr (hazInstr),
        .hazRs    (hazRs),
        .hazRt    (hazRt)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // One test per line, lines starting with # are skipped
    task automatic readTests();
        int    fd;
        int    n;
        string name;
        string line;
        fd = $fopen("verif/idTests.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/idTests.txt");
            otherErrors++;
            return;
        end
        while ($fscanf(fd, "%s", name) == 1 && numTests < MAX_TESTS) begin
            if (name.getc(0) == "#") begin
                n = $fgets(line, fd);   // Drop rest of comment
            end else begin
                n = 0;
                for (int i = 0; i < NUM_COLS; i++) begin
                    n += $fscanf(fd, "%h", cols[numTests][i]);
                end
                if (n != NUM_COLS) begin
                    $display("Test %s has missing or bad fields in the data file", name);
                    otherErrors++;
                end
                names[numTests] = name;
                numTests++;
            end
        end
        $fclose(fd);
    endtask

    task automatic applyStim(int t);
        code        = cols[t][0];
        pc          = cols[t][1];
        fwdEx.addr  = cols[t][2][4:0];
        fwdEx.data  = cols[t][3];
        fwdMem.addr = cols[t][4][4:0];
        fwdMem.data = cols[t][5];
        wbEn        = cols[t][6][0];
        wbAddr      = cols[t][7][4:0];
        wbData      = cols[t][8];
        tnewIn      = cols[t][9][1:0];
        stall       = cols[t][10][0];
        clr         = cols[t][11][0];
    endtask

    function automatic npcInfo expectedNpc(int t);
        npcInfo e;
        e.instr   = cols[t][12][5:0];
        e.cmp     = cols[t][13][0];
        e.imm16   = cols[t][14][15:0];
        e.jmpAddr = cols[t][15][25:0];
        e.jmpReg  = cols[t][16];
        return e;
    endfunction

    function automatic idExReg expectedIdEx(int t);
        idExReg e;
        e.instr        = cols[t][17][5:0];
        e.pc           = cols[t][18];
        e.dataRs       = cols[t][19];
        e.dataRt       = cols[t][20];
        e.imm16        = cols[t][21][15:0];
        e.shamt        = cols[t][22][4:0];
        e.addrRs       = cols[t][23][4:0];
        e.addrRt       = cols[t][24][4:0];
        e.regWriteAddr = cols[t][25][4:0];
        e.regWriteData = cols[t][26];
        e.tnew         = cols[t][27][1:0];
        return e;
    endfunction

    task automatic checkNpc(string name, npcInfo exp, npcInfo act);
        if (act !== exp) begin
            $display("Fail %s npc expected %h actual %h", name, exp, act);
            npcErrors++;
        end
    endtask

    task automatic checkIdEx(string name, idExReg exp, idExReg act);
        if (act !== exp) begin
            $display("Fail %s idEx expected %h actual %h", name, exp, act);
            idExErrors++;
        end
    endtask

    task automatic checkHaz(string name, opId expInstr, regAddr expRs, regAddr expRt,
                            opId actInstr, regAddr actRs, regAddr actRt);
        if (actInstr !== expInstr || actRs !== expRs || actRt !== expRt) begin
            $display("Fail %s haz expected %h %h %h actual %h %h %h", name,
                     expInstr, expRs, expRt, actInstr, actRs, actRt);
            hazErrors++;
        end
    endtask

    initial begin
        rst    = 1'b1;
        code   = '0;
        pc     = '0;
        fwdEx  = '0;
        fwdMem = '0;
        wbEn   = 1'b0;
        wbAddr = '0;
        wbData = '0;
        tnewIn = '0;
        stall  = 1'b0;
        clr    = 1'b0;
        readTests();
        loaded = 1'b1;
        if (numTests == 0) begin
            $display("No tests were read from verif/idTests.txt");
            otherErrors++;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int t = 0; t < numTests; t++) begin
            applyStim(t);
            #(PERIOD / 4);   // Mid low phase
            checkNpc(names[t], expectedNpc(t), npc);
            // Source registers are the rs and rt fields of the MIPS word
            checkHaz(names[t], cols[t][12][5:0], cols[t][0][25:21], cols[t][0][20:16],
                     hazInstr, hazRs, hazRt);
            @(posedge clk);
            #(PERIOD / 4);
            checkIdEx(names[t], expectedIdEx(t), idEx);
            @(negedge clk);
        end
        $display("Errors npc: %0d idEx: %0d haz: %0d other: %0d",
                 npcErrors, idExErrors, hazErrors, otherErrors);
        if (npcErrors + idExErrors + hazErrors + otherErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the test count
    initial begin
        wait (loaded);
        #((16 + 3 * numTests + 20) * PERIOD);
        $display("timeout: tests did not finish");
        $display("TESTS FAILED");
        $finish;
    end

endmodule
